// ==== design/link_pkg.sv ====
`default_nettype none

package link_pkg;

  // Serial timing, shortened for simulation
  localparam int CLKS_PER_BIT = 8;

  localparam logic [7:0] SYNC_REQ = 8'hAA;
  localparam logic [7:0] SYNC_RSP = 8'h55;
  localparam logic [7:0] CMD_WRITE = 8'h01;
  localparam logic [7:0] CMD_READ = 8'h02;
  localparam int MAX_LEN = 16;
  localparam logic [7:0] SW_ADDR = 8'hFF;

  localparam logic [15:0] CRC_INIT = 16'hFFFF;
  localparam logic [15:0] CRC_POLY = 16'h1021;

  localparam logic [7:0] ST_OK = 8'h00;
  localparam logic [7:0] ST_BAD_CMD = 8'h01;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_beat_t;

  typedef struct packed {
    logic       strobe;
    logic [7:0] addr;
    logic [7:0] data;
  } wr_req_t;

  typedef struct packed {
    logic [7:0] cmd;
    logic [7:0] addr;
    logic [4:0] len;
    logic [7:0] status;
  } reply_cmd_t;

  // CRC-16/CCITT, one byte at a time, MSB first
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc ^ {data, 8'h00};
    for (int i = 0; i < 8; i++) begin
      if (c[15]) begin
        c = {c[14:0], 1'b0} ^ CRC_POLY;
      end else begin
        c = {c[14:0], 1'b0};
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// ==== design/uart_rx.sv ====
`default_nettype none

module uart_rx (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           rxd,
  output link_pkg::byte_beat_t rx_beat
);

  localparam int CW = $clog2(link_pkg::CLKS_PER_BIT);
  localparam logic [CW-1:0] FULL = CW'(link_pkg::CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF = CW'(link_pkg::CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t        state;
  logic          rxd_meta;
  logic          rxd_sync;
  logic          rxd_prev;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shift;
  logic          rx_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rxd_prev && !rxd_sync) begin
            state <= S_START;
            cnt   <= '0;
          end
        end
        // Confirm the start bit at its middle, a glitch goes back to idle
        S_START: begin
          if (cnt == HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? S_IDLE : S_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (cnt == FULL) begin
            cnt     <= '0;
            shift   <= {rxd_sync, shift[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_STOP: begin
          if (cnt == FULL) begin
            cnt      <= '0;
            state    <= S_IDLE;
            rx_valid <= rxd_sync;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign rx_beat.valid = rx_valid;
  assign rx_beat.data  = shift;

endmodule

`default_nettype wire

// ==== design/frame_rx.sv ====
`default_nettype none

module frame_rx (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire link_pkg::byte_beat_t rx_beat,
  output link_pkg::wr_req_t         wr_req,
  output link_pkg::reply_cmd_t      cmd,
  output logic                      cmd_valid,
  input  wire logic                 cmd_ready
);

  localparam int IW = $clog2(link_pkg::MAX_LEN);

  typedef enum logic [3:0] {
    S_SYNC, S_CMD, S_ADDR, S_LEN, S_DATA, S_CRC_HI, S_CRC_LO, S_COMMIT, S_REPLY
  } state_t;

  state_t      state;
  logic [7:0]  cmd_byte;
  logic [7:0]  base_addr;
  logic [4:0]  len;
  logic [4:0]  cnt;
  logic [15:0] crc;
  logic [15:0] crc_next;
  logic [7:0]  crc_hi;
  logic [7:0]  stage [link_pkg::MAX_LEN];
  logic        len_ok;
  logic        is_write;

  assign crc_next = link_pkg::crc16_step(crc, rx_beat.data);
  assign len_ok   = rx_beat.data != 8'd0 && rx_beat.data <= 8'(link_pkg::MAX_LEN);
  assign is_write = cmd_byte == link_pkg::CMD_WRITE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_SYNC;
      cnt   <= '0;
      crc   <= link_pkg::CRC_INIT;
    end else begin
      case (state)
        S_SYNC: begin
          if (rx_beat.valid && rx_beat.data == link_pkg::SYNC_REQ) begin
            crc   <= link_pkg::CRC_INIT;
            state <= S_CMD;
          end
        end
        S_CMD: begin
          if (rx_beat.valid) begin
            crc   <= crc_next;
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (rx_beat.valid) begin
            crc   <= crc_next;
            state <= S_LEN;
          end
        end
        S_LEN: begin
          if (rx_beat.valid) begin
            crc   <= crc_next;
            cnt   <= '0;
            if (!len_ok) begin
              state <= S_SYNC;
            end else begin
              state <= is_write ? S_DATA : S_CRC_HI;
            end
          end
        end
        S_DATA: begin
          if (rx_beat.valid) begin
            crc <= crc_next;
            cnt <= cnt + 1'b1;
            if (cnt == len - 5'd1) begin
              state <= S_CRC_HI;
            end
          end
        end
        S_CRC_HI: begin
          if (rx_beat.valid) begin
            state <= S_CRC_LO;
          end
        end
        S_CRC_LO: begin
          if (rx_beat.valid) begin
            cnt <= '0;
            if ({crc_hi, rx_beat.data} != crc) begin
              state <= S_SYNC;
            end else begin
              state <= is_write ? S_COMMIT : S_REPLY;
            end
          end
        end
        // One staged byte per cycle into the register block
        S_COMMIT: begin
          cnt <= cnt + 1'b1;
          if (cnt == len - 5'd1) begin
            state <= S_REPLY;
          end
        end
        S_REPLY: begin
          if (cmd_ready) begin
            state <= S_SYNC;
          end
        end
        default: state <= S_SYNC;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_beat.valid) begin
      case (state)
        S_CMD:    cmd_byte <= rx_beat.data;
        S_ADDR:   base_addr <= rx_beat.data;
        S_LEN:    len <= rx_beat.data[4:0];
        S_DATA:   stage[cnt[IW-1:0]] <= rx_beat.data;
        S_CRC_HI: crc_hi <= rx_beat.data;
        default:  ;
      endcase
    end
  end

  // Address wraps at 255
  assign wr_req.strobe = state == S_COMMIT;
  assign wr_req.addr   = base_addr + {3'b000, cnt};
  assign wr_req.data   = stage[cnt[IW-1:0]];

  assign cmd.cmd    = cmd_byte;
  assign cmd.addr   = base_addr;
  assign cmd.len    = len;
  assign cmd.status = (is_write || cmd_byte == link_pkg::CMD_READ) ?
                      link_pkg::ST_OK : link_pkg::ST_BAD_CMD;
  assign cmd_valid  = state == S_REPLY;

endmodule

`default_nettype wire

// ==== design/reg_block.sv ====
`default_nettype none

module reg_block (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire link_pkg::wr_req_t wr_req,
  input  wire logic [7:0]        rd_addr,
  output logic [7:0]             rd_data,
  input  wire logic [7:0]        sw,
  output logic [7:0]             led
);

  // The top address is the switch window, so only 255 bytes are stored
  localparam int DEPTH = 255;

  logic [7:0] regs [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_req.strobe && wr_req.addr != link_pkg::SW_ADDR) begin
      regs[wr_req.addr] <= wr_req.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_addr == link_pkg::SW_ADDR) begin
      rd_data <= sw;
    end else begin
      rd_data <= regs[rd_addr];
    end
  end

  assign led = regs[0];

endmodule

`default_nettype wire

// ==== design/reply_tx.sv ====
`default_nettype none

module reply_tx (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire link_pkg::reply_cmd_t   cmd,
  input  wire logic                   cmd_valid,
  output logic                        cmd_ready,
  output logic [7:0]                  rd_addr,
  input  wire logic [7:0]             rd_data,
  output link_pkg::byte_beat_t        tx_beat,
  input  wire logic                   tx_ready
);

  typedef enum logic [2:0] {S_IDLE, S_HDR, S_FETCH, S_DATA, S_CRC_HI, S_CRC_LO} state_t;

  state_t               state;
  link_pkg::reply_cmd_t rc;
  logic [2:0]           hdr_idx;
  logic [7:0]           hdr_next;
  logic [4:0]           cnt;
  logic [15:0]          crc;
  logic [7:0]           rd_ptr;
  logic                 tx_valid;
  logic [7:0]           tx_data;
  logic                 taken;
  logic                 has_data;

  assign taken     = tx_valid && tx_ready;
  assign has_data  = rc.cmd == link_pkg::CMD_READ && rc.status == link_pkg::ST_OK;
  assign cmd_ready = state == S_IDLE;
  assign rd_addr   = rd_ptr;

  assign tx_beat.valid = tx_valid;
  assign tx_beat.data  = tx_data;

  // hdr_idx names the byte now on offer, 0 is the sync byte
  always_comb begin
    case (hdr_idx)
      3'd0:    hdr_next = rc.cmd;
      3'd1:    hdr_next = rc.addr;
      3'd2:    hdr_next = {3'b000, rc.len};
      default: hdr_next = rc.status;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      tx_valid <= 1'b0;
      hdr_idx  <= '0;
      cnt      <= '0;
      crc      <= link_pkg::CRC_INIT;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid) begin
            rc       <= cmd;
            rd_ptr   <= cmd.addr;
            tx_data  <= link_pkg::SYNC_RSP;
            tx_valid <= 1'b1;
            hdr_idx  <= '0;
            cnt      <= '0;
            crc      <= link_pkg::CRC_INIT;
            state    <= S_HDR;
          end
        end
        S_HDR: begin
          if (taken) begin
            if (hdr_idx != 3'd4) begin
              tx_data <= hdr_next;
              crc     <= link_pkg::crc16_step(crc, hdr_next);
              hdr_idx <= hdr_idx + 1'b1;
            end else if (has_data) begin
              tx_valid <= 1'b0;
              state    <= S_FETCH;
            end else begin
              tx_data <= crc[15:8];
              state   <= S_CRC_HI;
            end
          end
        end
        // rd_data already holds rd_ptr, step the pointer one address ahead
        S_FETCH: begin
          tx_data  <= rd_data;
          tx_valid <= 1'b1;
          crc      <= link_pkg::crc16_step(crc, rd_data);
          rd_ptr   <= rd_ptr + 1'b1;
          cnt      <= cnt + 1'b1;
          state    <= S_DATA;
        end
        S_DATA: begin
          if (taken) begin
            if (cnt == rc.len) begin
              tx_data <= crc[15:8];
              state   <= S_CRC_HI;
            end else begin
              tx_valid <= 1'b0;
              state    <= S_FETCH;
            end
          end
        end
        S_CRC_HI: begin
          if (taken) begin
            tx_data <= crc[7:0];
            state   <= S_CRC_LO;
          end
        end
        S_CRC_LO: begin
          if (taken) begin
            tx_valid <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire link_pkg::byte_beat_t tx_beat,
  output logic                      tx_ready,
  output logic                      txd
);

  localparam int CW = $clog2(link_pkg::CLKS_PER_BIT);
  localparam logic [CW-1:0] FULL = CW'(link_pkg::CLKS_PER_BIT - 1);

  logic          busy;
  logic [CW-1:0] cnt;
  logic [3:0]    bit_idx;
  logic [9:0]    shift;

  assign tx_ready = !busy;
  assign txd      = shift[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      shift   <= '1;
    end else if (!busy) begin
      if (tx_beat.valid) begin
        // Stop, data LSB first, start
        shift   <= {1'b1, tx_beat.data, 1'b0};
        busy    <= 1'b1;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end else if (cnt == FULL) begin
      cnt   <= '0;
      shift <= {1'b1, shift[9:1]};
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/serial_link_top.sv ====
`default_nettype none

module serial_link_top (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       rxd,
  input  wire logic [7:0] sw,
  output logic            txd,
  output logic [7:0]      led
);

  link_pkg::byte_beat_t rx_beat;
  link_pkg::byte_beat_t tx_beat;
  link_pkg::wr_req_t    wr_req;
  link_pkg::reply_cmd_t cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 tx_ready;
  logic [7:0]           rd_addr;
  logic [7:0]           rd_data;

  uart_rx uart_rx (.clk(clk),
                   .rst_n(rst_n),
                   .rxd(rxd),
                   .rx_beat(rx_beat));

  frame_rx frame_rx (.clk(clk),         .wr_req(wr_req),
                     .rst_n(rst_n),     .cmd(cmd),
                     .rx_beat(rx_beat), .cmd_valid(cmd_valid),
                     .cmd_ready(cmd_ready));

  reg_block reg_block (.clk(clk),         .rd_data(rd_data),
                       .rst_n(rst_n),     .led(led),
                       .wr_req(wr_req),
                       .rd_addr(rd_addr),
                       .sw(sw));

  reply_tx reply_tx (.clk(clk),             .cmd_ready(cmd_ready),
                     .rst_n(rst_n),         .rd_addr(rd_addr),
                     .cmd(cmd),             .tx_beat(tx_beat),
                     .cmd_valid(cmd_valid),
                     .rd_data(rd_data),
                     .tx_ready(tx_ready));

  uart_tx uart_tx (.clk(clk),         .tx_ready(tx_ready),
                   .rst_n(rst_n),     .txd(txd),
                   .tx_beat(tx_beat));

endmodule

`default_nettype wire

// ==== bench/tb_serial_link.sv ====
`default_nettype none

module tb_serial_link;

  localparam int     BIT_CYCLES   = link_pkg::CLKS_PER_BIT;
  localparam int     NUM_FRAMES   = 29;
  localparam int     REPLY_LIMIT  = 40 + 25 * 10 * BIT_CYCLES;
  localparam int     QUIET_CYCLES = 60 + 10 * BIT_CYCLES;
  localparam longint TIMEOUT      = longint'(NUM_FRAMES) * 30 * 10 * BIT_CYCLES * 20;

  logic       clk;
  logic       rst_n;
  logic       rxd;
  logic [7:0] sw;
  logic       txd;
  logic [7:0] led;

  logic [7:0] ref_mem [256];
  logic [7:0] payload [link_pkg::MAX_LEN];
  logic [7:0] frame_q [$];
  logic [7:0] exp_q [$];
  logic [7:0] rsp_q [$];
  integer     seed;
  int         errors;
  int         errors_at_start;
  int         pass_count;
  int         fail_count;

  serial_link_top UUT (
    .clk(clk),
    .rst_n(rst_n),
    .rxd(rxd),
    .sw(sw),
    .txd(txd),
    .led(led)
  );

  always #10 clk = ~clk;

  // Bitwise CRC-16, MSB first
  function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[15] ^ data[i];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ link_pkg::CRC_POLY;
      end
    end
    return c;
  endfunction

  function automatic void build_request(input logic [7:0] cmd, input logic [7:0] addr,
                                        input logic [4:0] len, input logic corrupt);
    logic [15:0] crc;
    frame_q.delete();
    frame_q.push_back(link_pkg::SYNC_REQ);
    frame_q.push_back(cmd);
    frame_q.push_back(addr);
    frame_q.push_back({3'b000, len});
    if (cmd == link_pkg::CMD_WRITE) begin
      for (int i = 0; i < len; i++) begin
        frame_q.push_back(payload[i]);
      end
    end
    crc = link_pkg::CRC_INIT;
    for (int i = 1; i < frame_q.size(); i++) begin
      crc = crc_update(crc, frame_q[i]);
    end
    if (corrupt) begin
      crc = crc ^ 16'h0001;
    end
    frame_q.push_back(crc[15:8]);
    frame_q.push_back(crc[7:0]);
  endfunction

  // Reference model, applies a good frame to the memory image and builds its reply
  function automatic void expected_reply(input logic [7:0] cmd, input logic [7:0] addr,
                                         input logic [4:0] len);
    logic [15:0] crc;
    logic [7:0]  a;
    logic [7:0]  status;
    status = (cmd == link_pkg::CMD_WRITE || cmd == link_pkg::CMD_READ) ?
             link_pkg::ST_OK : link_pkg::ST_BAD_CMD;
    exp_q.delete();
    exp_q.push_back(link_pkg::SYNC_RSP);
    exp_q.push_back(cmd);
    exp_q.push_back(addr);
    exp_q.push_back({3'b000, len});
    exp_q.push_back(status);
    for (int i = 0; i < len; i++) begin
      a = 8'(addr + i);
      if (cmd == link_pkg::CMD_WRITE && a != link_pkg::SW_ADDR) begin
        ref_mem[a] = payload[i];
      end else if (cmd == link_pkg::CMD_READ) begin
        exp_q.push_back(a == link_pkg::SW_ADDR ? sw : ref_mem[a]);
      end
    end
    crc = link_pkg::CRC_INIT;
    for (int i = 1; i < exp_q.size(); i++) begin
      crc = crc_update(crc, exp_q[i]);
    end
    exp_q.push_back(crc[15:8]);
    exp_q.push_back(crc[7:0]);
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %02h expected %02h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Start, eight data bits LSB first, stop
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
      #2;
    end
  endtask

  task automatic run_frame(input logic [7:0] cmd, input logic [7:0] addr,
                           input logic [4:0] len, input logic corrupt);
    logic good;
    logic saw_start;
    int   waited;
    good = !corrupt && len != 5'd0 && len <= 5'(link_pkg::MAX_LEN);
    build_request(cmd, addr, len, corrupt);
    if (good) begin
      expected_reply(cmd, addr, len);
    end
    rsp_q.delete();
    foreach (frame_q[i]) begin
      send_byte(frame_q[i]);
    end
    if (good) begin
      waited = 0;
      while (rsp_q.size() < exp_q.size() && waited < REPLY_LIMIT) begin
        @(posedge clk);
        #2;
        waited++;
      end
      if (rsp_q.size() < exp_q.size()) begin
        $display("No complete reply to command %02h at address %02h: %0d of %0d bytes",
                 cmd, addr, rsp_q.size(), exp_q.size());
        errors++;
      end else begin
        foreach (exp_q[i]) begin
          check_value($sformatf("reply byte %0d", i), rsp_q[i], exp_q[i]);
        end
      end
    end else begin
      saw_start = 1'b0;
      repeat (QUIET_CYCLES) begin
        @(posedge clk);
        #2;
        if (!txd) begin
          saw_start = 1'b1;
        end
      end
      if (saw_start || rsp_q.size() != 0) begin
        $display("A rejected frame to address %02h was answered at %0t", addr, $time);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      pass_count++;
      $display("Test %s: ok", name);
    end else begin
      fail_count++;
      $display("Test %s: %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Decodes txd at the middle of each bit
  initial begin : txd_monitor
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (rst_n && !txd) begin
        repeat (BIT_CYCLES / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CYCLES) @(negedge clk);
          b[i] = txd;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (!txd) begin
          $display("Stop bit on txd was low at %0t", $time);
          errors++;
        end
        rsp_q.push_back(b);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  addr;
    logic [4:0]  len;
    logic [15:0] crc;
    clk = 1'b0;
    rst_n = 1'b0;
    rxd = 1'b1;
    sw = 8'h5A;
    seed = 79;
    errors = 0;
    errors_at_start = 0;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #2;

    check_value("txd", {7'b0000000, txd}, 8'h01);
    check_value("led", led, 8'h00);
    for (int i = 0; i < 4; i++) begin
      payload[i] = 8'($random(seed));
    end
    run_frame(link_pkg::CMD_WRITE, 8'h20, 5'd4, 1'b0);
    run_frame(link_pkg::CMD_READ, 8'h20, 5'd4, 1'b0);
    end_test("write then read back");

    payload[0] = 8'hA5;
    run_frame(link_pkg::CMD_WRITE, 8'h00, 5'd1, 1'b0);
    check_value("led", led, 8'hA5);
    end_test("led mirror");

    payload[0] = 8'h3C;
    run_frame(link_pkg::CMD_WRITE, 8'hFE, 5'd1, 1'b0);
    run_frame(link_pkg::CMD_READ, 8'hFE, 5'd2, 1'b0);
    end_test("switch window");

    for (int i = 0; i < 4; i++) begin
      payload[i] = 8'($random(seed));
    end
    run_frame(link_pkg::CMD_WRITE, 8'h20, 5'd4, 1'b1);
    // A CRC byte equal to the sync byte would open a new frame in the parser
    addr = 8'h0F;
    do begin
      addr = addr + 8'd1;
      crc = crc_update(crc_update(crc_update(link_pkg::CRC_INIT, link_pkg::CMD_READ), addr),
                       8'h00);
    end while (crc[15:8] == link_pkg::SYNC_REQ || crc[7:0] == link_pkg::SYNC_REQ);
    run_frame(link_pkg::CMD_READ, addr, 5'd0, 1'b0);
    run_frame(link_pkg::CMD_READ, 8'h20, 5'd4, 1'b0);
    end_test("corrupted frames");

    run_frame(8'h07, 8'h30, 5'd3, 1'b0);
    end_test("unknown command");

    for (int n = 0; n < 20; n++) begin
      r = $random(seed);
      addr = r[7:0];
      if (n % 4 == 0) begin
        addr = {4'hF, r[11:8]};
      end
      len = {1'b0, r[15:12]} + 5'd1;
      for (int i = 0; i < link_pkg::MAX_LEN; i++) begin
        payload[i] = 8'($random(seed));
      end
      run_frame(r[16] ? link_pkg::CMD_WRITE : link_pkg::CMD_READ, addr, len, 1'b0);
    end
    end_test("random traffic");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/link_pkg.sv
design/uart_rx.sv
design/frame_rx.sv
design/reg_block.sv
design/reply_tx.sv
design/uart_tx.sv
design/serial_link_top.sv
bench/tb_serial_link.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_serial_link
FILELIST  := compile.f
BUILD_DIR := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
